//--- radio_ctrl_pkg.sv
/* radio control package
   command, response and envelope types shared by the transmit control path */
package radio_ctrl_pkg;

  // ---------------------------------------------------------
  // host command bus
  // ---------------------------------------------------------

  // register address of a host command
  typedef logic [5:0]  cmd_addr_t;
  // command payload
  typedef logic [31:0] cmd_data_t;

  // acknowledged command as returned to the host
  // address sits in the upper bits
  typedef struct packed {
    cmd_addr_t addr;
    cmd_data_t data;
  } response_t;

  // last active receive channel
  typedef logic [4:0]  chan_t;
  // cw envelope amplitude
  typedef logic [17:0] cw_level_t;

  // ---------------------------------------------------------
  // register map
  // ---------------------------------------------------------

  // receive control, last channel in data[7:3]
  localparam cmd_addr_t CMD_ADDR_RX_CTRL = 6'h00;
  // transmit control, vna / pa / t/r flags
  localparam cmd_addr_t CMD_ADDR_TX_CTRL = 6'h09;

  localparam int LAST_CHAN_LSB  = 3;
  localparam int VNA_BIT        = 23;
  localparam int PA_ENABLE_BIT  = 19;
  localparam int TR_DISABLE_BIT = 18;

  // ramp ceiling, eight times the cordic full scale
  localparam cw_level_t CW_LEVEL_MAX_DEFAULT = 18'h26C00;

endpackage

//--- input_debounce.sv
/* input debounce
   stable-count filter for one raw active-low panel input */
`timescale 1ns/1ps

module input_debounce #(
  parameter int CYCLES = 12500
) (
  input  logic clock_2_5MHz,
  input  logic rst,
  input  logic raw_n_i,
  output logic clean_o
);

  // counter must reach CYCLES - 1
  localparam int CNT_W = $clog2(CYCLES + 1);

  logic             raw;
  logic             clean_q;
  logic [CNT_W-1:0] cnt_q;

  // active high view of the pin
  assign raw = ~raw_n_i;

  always_ff @(posedge clock_2_5MHz)
  begin
    if (rst)
    begin
      clean_q <= 1'b0;
      cnt_q   <= '0;
    end
    else if (raw == clean_q)
    begin
      // agreement restarts the run
      cnt_q <= '0;
    end
    else if (cnt_q == CNT_W'(CYCLES - 1))
    begin
      // CYCLES disagreeing samples in a row
      clean_q <= raw;
      cnt_q   <= '0;
    end
    else
    begin
      cnt_q <= cnt_q + CNT_W'(1);
    end
  end

  assign clean_o = clean_q;

endmodule

//--- cw_keyer.sv
/* cw keyer
   debounced key shaped into a linear rise and fall of the transmit envelope */
`timescale 1ns/1ps

module cw_keyer #(
  parameter int                        DEBOUNCE_CYCLES = 12500,
  parameter radio_ctrl_pkg::cw_level_t LEVEL_MAX       = radio_ctrl_pkg::CW_LEVEL_MAX_DEFAULT
) (
  input  logic                      clock_2_5MHz,
  input  logic                      rst,
  input  logic                      cwkey_n_i,
  output logic                      cw_active_o,
  output radio_ctrl_pkg::cw_level_t cw_level_o
);

  // keyer states
  typedef enum logic [1:0] {
    CW_IDLE     = 2'b00,
    CW_KEY_DOWN = 2'b01,
    CW_KEY_UP   = 2'b11
  } cw_state_t;

  cw_state_t                 state_q;
  radio_ctrl_pkg::cw_level_t level_q;
  logic                      clean_key;

  // key contact bounce filter
  input_debounce #(
    .CYCLES (DEBOUNCE_CYCLES)
  ) key_debounce (
    .clock_2_5MHz (clock_2_5MHz),
    .rst          (rst),
    .raw_n_i      (cwkey_n_i),
    .clean_o      (clean_key)
  );

  // ---------------------------------------------------------
  // envelope state machine
  // ---------------------------------------------------------
  always_ff @(posedge clock_2_5MHz)
  begin
    if (rst)
    begin
      state_q <= CW_IDLE;
      level_q <= '0;
    end
    else
    begin
      case (state_q)
        CW_IDLE:
        begin
          level_q <= '0;
          if (clean_key)
            state_q <= CW_KEY_DOWN;
        end
        CW_KEY_DOWN:
        begin
          // ramp up then hold at the ceiling
          if (level_q < LEVEL_MAX)
            level_q <= level_q + radio_ctrl_pkg::cw_level_t'(1);
          if (!clean_key)
            state_q <= CW_KEY_UP;
        end
        CW_KEY_UP:
        begin
          // ramp down fully even if the key returns
          if (level_q == '0)
            state_q <= CW_IDLE;
          else
            level_q <= level_q - radio_ctrl_pkg::cw_level_t'(1);
        end
        default:
        begin
          state_q <= CW_IDLE;
          level_q <= '0;
        end
      endcase
    end
  end

  // transmitting for the whole ramp
  assign cw_active_o = (state_q != CW_IDLE);
  assign cw_level_o  = level_q;

endmodule

//--- cmd_decoder.sv
/* command decoder
   host command strobe to rx/tx control registers, plus response words */
`timescale 1ns/1ps

module cmd_decoder (
  input  logic                      clock_2_5MHz,
  input  logic                      rst,
  input  radio_ctrl_pkg::cmd_addr_t cmd_addr_i,
  input  radio_ctrl_pkg::cmd_data_t cmd_data_i,
  input  logic                      cmd_rqst_i,
  input  logic                      cmd_resprqst_i,
  input  logic                      push_ready_i,
  output logic                      push_valid_o,
  output radio_ctrl_pkg::response_t push_data_o,
  output radio_ctrl_pkg::chan_t     last_chan_o,
  output logic                      vna_o,
  output logic                      pa_enable_o,
  output logic                      tr_disable_o
);

  radio_ctrl_pkg::chan_t last_chan_q;
  logic                  vna_q;
  logic                  pa_enable_q;
  logic                  tr_disable_q;

  // ---------------------------------------------------------
  // control registers
  // ---------------------------------------------------------
  always_ff @(posedge clock_2_5MHz)
  begin
    if (rst)
    begin
      // single receiver, vna off, pa off
      last_chan_q  <= '0;
      vna_q        <= 1'b0;
      pa_enable_q  <= 1'b0;
      tr_disable_q <= 1'b0;
    end
    else if (cmd_rqst_i)
    begin
      if (cmd_addr_i == radio_ctrl_pkg::CMD_ADDR_RX_CTRL)
      begin
        // number of iq streams to the host
        last_chan_q <= cmd_data_i[radio_ctrl_pkg::LAST_CHAN_LSB +: $bits(radio_ctrl_pkg::chan_t)];
      end
      if (cmd_addr_i == radio_ctrl_pkg::CMD_ADDR_TX_CTRL)
      begin
        vna_q        <= cmd_data_i[radio_ctrl_pkg::VNA_BIT];
        pa_enable_q  <= cmd_data_i[radio_ctrl_pkg::PA_ENABLE_BIT];
        tr_disable_q <= cmd_data_i[radio_ctrl_pkg::TR_DISABLE_BIT];
      end
      // other addresses belong to blocks outside this path
    end
  end

  // ---------------------------------------------------------
  // response producer
  // ---------------------------------------------------------

  // every address is acknowledged when asked
  // full queue drops the word, registers still update
  assign push_valid_o = cmd_rqst_i & cmd_resprqst_i & push_ready_i;

  // echo of the command as sampled on the strobe
  assign push_data_o.addr = cmd_addr_i;
  assign push_data_o.data = cmd_data_i;

  assign last_chan_o  = last_chan_q;
  assign vna_o        = vna_q;
  assign pa_enable_o  = pa_enable_q;
  assign tr_disable_o = tr_disable_q;

endmodule

//--- response_fifo.sv
/* response queue
   show-ahead circular buffer holding acknowledged commands for the host */
`timescale 1ns/1ps

module response_fifo #(
  parameter int DEPTH = 4
) (
  input  logic                      clock_2_5MHz,
  input  logic                      rst,
  input  logic                      push_valid_i,
  input  radio_ctrl_pkg::response_t push_data_i,
  output logic                      push_ready_o,
  input  logic                      pop_ready_i,
  output logic                      pop_valid_o,
  output radio_ctrl_pkg::response_t pop_data_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  radio_ctrl_pkg::response_t mem [DEPTH];
  logic [PTR_W-1:0]          wr_ptr_q;
  logic [PTR_W-1:0]          rd_ptr_q;
  logic [CNT_W-1:0]          count_q;
  logic                      push;
  logic                      pop;

  // wrap at DEPTH, not at a power of two
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1))
      return '0;
    return ptr + PTR_W'(1);
  endfunction

  assign push_ready_o = (count_q != CNT_W'(DEPTH));
  assign pop_valid_o  = (count_q != '0);
  // head word visible while valid
  assign pop_data_o   = mem[rd_ptr_q];

  assign push = push_valid_i & push_ready_o;
  assign pop  = pop_valid_o & pop_ready_i;

  // storage
  always_ff @(posedge clock_2_5MHz)
  begin
    if (push)
      mem[wr_ptr_q] <= push_data_i;
  end

  // pointers and occupancy
  always_ff @(posedge clock_2_5MHz)
  begin
    if (rst)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr_q <= next_ptr(wr_ptr_q);
      if (pop)
        rd_ptr_q <= next_ptr(rd_ptr_q);
      // simultaneous push and pop leaves the count alone
      case ({push, pop})
        2'b10:   count_q <= count_q + CNT_W'(1);
        2'b01:   count_q <= count_q - CNT_W'(1);
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

//--- tx_switching.sv
/* transmit switching
   ptt combine with inhibit, and the pa, t/r and rf switch controls */
`timescale 1ns/1ps

module tx_switching #(
  parameter int DEBOUNCE_CYCLES = 12500
) (
  input  logic clock_2_5MHz,
  input  logic rst,
  input  logic ptt_n_i,
  input  logic txinhibit_n_i,
  input  logic cmd_ptt_i,
  input  logic cw_active_i,
  input  logic vna_i,
  input  logic pa_enable_i,
  input  logic tr_disable_i,
  output logic ptt_o,
  output logic tx_en_o,
  output logic pa_inttr_o,
  output logic pa_exttr_o,
  output logic pwr_envpa_o,
  output logic rfsw_sel_o
);

  logic clean_ptt;
  logic clean_inhibit;
  logic ptt;

  // panel ptt switch
  input_debounce #(
    .CYCLES (DEBOUNCE_CYCLES)
  ) ptt_debounce (
    .clock_2_5MHz (clock_2_5MHz),
    .rst          (rst),
    .raw_n_i      (ptt_n_i),
    .clean_o      (clean_ptt)
  );

  // external amplifier or sequencer inhibit
  input_debounce #(
    .CYCLES (DEBOUNCE_CYCLES)
  ) inhibit_debounce (
    .clock_2_5MHz (clock_2_5MHz),
    .rst          (rst),
    .raw_n_i      (txinhibit_n_i),
    .clean_o      (clean_inhibit)
  );

  // host, keyer or panel request, inhibit wins
  assign ptt = (cmd_ptt_i | cw_active_i | clean_ptt) & ~clean_inhibit;

  assign ptt_o       = ptt;
  // dac also runs for vna sweeps
  assign tx_en_o     = ptt | vna_i;
  assign pa_exttr_o  = ptt;
  // internal relay skipped only when pa off and t/r disabled
  assign pa_inttr_o  = ptt & (pa_enable_i | ~tr_disable_i);
  assign pwr_envpa_o = ptt & pa_enable_i;
  // route through the pa when enabled
  assign rfsw_sel_o  = pa_enable_i;

endmodule

//--- radio_ctrl_top.sv
/* radio control top
   command decode, response queue, cw keyer and transmit switching */
`timescale 1ns/1ps

module radio_ctrl_top #(
  parameter int                        DEBOUNCE_CYCLES = 12500,
  parameter radio_ctrl_pkg::cw_level_t CW_LEVEL_MAX    = radio_ctrl_pkg::CW_LEVEL_MAX_DEFAULT,
  parameter int                        RESP_DEPTH      = 4
) (
  input  logic                      clock_2_5MHz,
  input  logic                      rst,
  // host command port
  input  radio_ctrl_pkg::cmd_addr_t cmd_addr_i,
  input  radio_ctrl_pkg::cmd_data_t cmd_data_i,
  input  logic                      cmd_rqst_i,
  input  logic                      cmd_resprqst_i,
  input  logic                      cmd_ptt_i,
  // raw front panel, active low
  input  logic                      cwkey_n_i,
  input  logic                      ptt_n_i,
  input  logic                      txinhibit_n_i,
  // host response port
  input  logic                      resp_ready_i,
  output logic                      resp_valid_o,
  output radio_ctrl_pkg::response_t resp_data_o,
  // transmit state
  output logic                      ptt_o,
  output logic                      tx_en_o,
  output logic                      cw_active_o,
  output radio_ctrl_pkg::cw_level_t cw_level_o,
  output radio_ctrl_pkg::chan_t     last_chan_o,
  output logic                      vna_o,
  // pa and rf front end
  output logic                      pa_inttr_o,
  output logic                      pa_exttr_o,
  output logic                      pwr_envpa_o,
  output logic                      rfsw_sel_o
);

  logic                      push_valid;
  logic                      push_ready;
  radio_ctrl_pkg::response_t push_data;
  logic                      pa_enable;
  logic                      tr_disable;

  cmd_decoder cmd_decoder_inst (
    .clock_2_5MHz   (clock_2_5MHz),
    .rst            (rst),
    .cmd_addr_i     (cmd_addr_i),
    .cmd_data_i     (cmd_data_i),
    .cmd_rqst_i     (cmd_rqst_i),
    .cmd_resprqst_i (cmd_resprqst_i),
    .push_ready_i   (push_ready),
    .push_valid_o   (push_valid),
    .push_data_o    (push_data),
    .last_chan_o    (last_chan_o),
    .vna_o          (vna_o),
    .pa_enable_o    (pa_enable),
    .tr_disable_o   (tr_disable)
  );

  response_fifo #(
    .DEPTH (RESP_DEPTH)
  ) response_fifo_inst (
    .clock_2_5MHz (clock_2_5MHz),
    .rst          (rst),
    .push_valid_i (push_valid),
    .push_data_i  (push_data),
    .push_ready_o (push_ready),
    .pop_ready_i  (resp_ready_i),
    .pop_valid_o  (resp_valid_o),
    .pop_data_o   (resp_data_o)
  );

  cw_keyer #(
    .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES),
    .LEVEL_MAX       (CW_LEVEL_MAX)
  ) cw_keyer_inst (
    .clock_2_5MHz (clock_2_5MHz),
    .rst          (rst),
    .cwkey_n_i    (cwkey_n_i),
    .cw_active_o  (cw_active_o),
    .cw_level_o   (cw_level_o)
  );

  tx_switching #(
    .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
  ) tx_switching_inst (
    .clock_2_5MHz  (clock_2_5MHz),
    .rst           (rst),
    .ptt_n_i       (ptt_n_i),
    .txinhibit_n_i (txinhibit_n_i),
    .cmd_ptt_i     (cmd_ptt_i),
    .cw_active_i   (cw_active_o),
    .vna_i         (vna_o),
    .pa_enable_i   (pa_enable),
    .tr_disable_i  (tr_disable),
    .ptt_o         (ptt_o),
    .tx_en_o       (tx_en_o),
    .pa_inttr_o    (pa_inttr_o),
    .pa_exttr_o    (pa_exttr_o),
    .pwr_envpa_o   (pwr_envpa_o),
    .rfsw_sel_o    (rfsw_sel_o)
  );

endmodule

//--- radio_ctrl_checker.sv
/* radio control checker
   concurrent assertions on envelope, response port and pa outputs of the top level */
`timescale 1ns/1ps

module radio_ctrl_checker #(
  parameter radio_ctrl_pkg::cw_level_t LEVEL_MAX = radio_ctrl_pkg::CW_LEVEL_MAX_DEFAULT
) (
  input logic                      clock_2_5MHz,
  input logic                      rst,
  input logic                      resp_valid_i,
  input logic                      resp_ready_i,
  input radio_ctrl_pkg::response_t resp_data_i,
  input radio_ctrl_pkg::cw_level_t cw_level_i,
  input logic                      pwr_envpa_i,
  input logic                      pa_exttr_i
);

  // read by the testbench for the verdict
  int assert_failures = 0;

  // envelope never above its ceiling
  level_ceiling_a: assert property (@(posedge clock_2_5MHz) disable iff (rst)
    cw_level_i <= LEVEL_MAX)
  else
  begin
    assert_failures++;
    $error("cw_level_o above ceiling");
  end

  // linear ramp, one step per cycle at most
  level_step_a: assert property (@(posedge clock_2_5MHz) disable iff (rst)
    (cw_level_i == $past(cw_level_i)) ||
    (cw_level_i == $past(cw_level_i) + 1) ||
    (cw_level_i + 1 == $past(cw_level_i)))
  else
  begin
    assert_failures++;
    $error("cw_level_o changed by more than one step");
  end

  // head word held while the host stalls
  resp_stable_a: assert property (@(posedge clock_2_5MHz) disable iff (rst)
    (resp_valid_i && !resp_ready_i) |=> (resp_valid_i && $stable(resp_data_i)))
  else
  begin
    assert_failures++;
    $error("response word changed while stalled");
  end

  // pa bias only together with external t/r
  pa_exttr_a: assert property (@(posedge clock_2_5MHz) disable iff (rst)
    pwr_envpa_i |-> pa_exttr_i)
  else
  begin
    assert_failures++;
    $error("pwr_envpa_o high without pa_exttr_o");
  end

endmodule

//--- tb_radio_ctrl.sv
/* radio control testbench
   reset, command decode, response queue, cw envelope and transmit switching */
`timescale 1ns/1ps

module tb_radio_ctrl;

  localparam int                        DEBOUNCE   = 8;
  localparam radio_ctrl_pkg::cw_level_t LEVEL_MAX  = 40;
  localparam int                        RESP_DEPTH = 4;
  localparam int                        N_DECODE   = 24;
  localparam int                        N_QUEUE    = 40;
  localparam int                        N_TX       = 24;
  // 20 cycles per command, four ramps, fixed margin
  localparam int WATCHDOG_CYCLES = (N_DECODE + N_QUEUE + N_TX) * 20 + 4 * LEVEL_MAX + 2000;

  logic                      clock_2_5MHz;
  logic                      rst;
  radio_ctrl_pkg::cmd_addr_t cmd_addr_i;
  radio_ctrl_pkg::cmd_data_t cmd_data_i;
  logic                      cmd_rqst_i;
  logic                      cmd_resprqst_i;
  logic                      cmd_ptt_i;
  logic                      cwkey_n_i;
  logic                      ptt_n_i;
  logic                      txinhibit_n_i;
  logic                      resp_ready_i;
  logic                      resp_valid_o;
  radio_ctrl_pkg::response_t resp_data_o;
  logic                      ptt_o;
  logic                      tx_en_o;
  logic                      cw_active_o;
  radio_ctrl_pkg::cw_level_t cw_level_o;
  radio_ctrl_pkg::chan_t     last_chan_o;
  logic                      vna_o;
  logic                      pa_inttr_o;
  logic                      pa_exttr_o;
  logic                      pwr_envpa_o;
  logic                      rfsw_sel_o;

  int mismatch_count = 0;
  int other_errors   = 0;
  int dropped_resp   = 0;

  // shadow of the control registers
  radio_ctrl_pkg::chan_t     exp_chan = '0;
  logic                      exp_vna  = 1'b0;
  logic                      exp_pa   = 1'b0;
  logic                      exp_tr   = 1'b0;
  // accepted responses still waiting for the host
  radio_ctrl_pkg::response_t resp_model [$];

  radio_ctrl_top #(
    .DEBOUNCE_CYCLES (DEBOUNCE),
    .CW_LEVEL_MAX    (LEVEL_MAX),
    .RESP_DEPTH      (RESP_DEPTH)
  ) radio_ctrl_top_inst (.*);

  bind radio_ctrl_top radio_ctrl_checker #(
    .LEVEL_MAX (CW_LEVEL_MAX)
  ) radio_ctrl_checker_inst (
    .clock_2_5MHz (clock_2_5MHz),
    .rst          (rst),
    .resp_valid_i (resp_valid_o),
    .resp_ready_i (resp_ready_i),
    .resp_data_i  (resp_data_o),
    .cw_level_i   (cw_level_o),
    .pwr_envpa_i  (pwr_envpa_o),
    .pa_exttr_i   (pa_exttr_o)
  );

  // 200 ns period
  always #100 clock_2_5MHz = ~clock_2_5MHz;

  // ------------------------------------------------------------
  // compare tasks
  // ------------------------------------------------------------
  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
      mismatch_count++;
      $display("MISMATCH at %0t: %s expected %b got %b", $time, name, exp, act);
    end
  endtask

  task automatic check_level(input string name, input radio_ctrl_pkg::cw_level_t exp,
                             input radio_ctrl_pkg::cw_level_t act);
    if (act !== exp)
    begin
      mismatch_count++;
      $display("MISMATCH at %0t: %s expected %0d got %0d", $time, name, exp, act);
    end
  endtask

  task automatic check_chan(input string name, input radio_ctrl_pkg::chan_t exp,
                            input radio_ctrl_pkg::chan_t act);
    if (act !== exp)
    begin
      mismatch_count++;
      $display("MISMATCH at %0t: %s expected %0d got %0d", $time, name, exp, act);
    end
  endtask

  task automatic check_resp(input string name, input radio_ctrl_pkg::response_t exp,
                            input radio_ctrl_pkg::response_t act);
    if (act !== exp)
    begin
      mismatch_count++;
      $display("MISMATCH at %0t: %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  // expected {ptt, tx_en, pa_inttr, pa_exttr, pwr_envpa, rfsw_sel}
  function automatic logic [5:0] tx_reference(input logic host_ptt, input logic cw_act,
                                              input logic panel_ptt, input logic inhibit,
                                              input logic vna, input logic pa_en,
                                              input logic tr_dis);
    logic ptt;
    // any request, unless inhibited
    ptt = (host_ptt || cw_act || panel_ptt) && !inhibit;
    return {ptt, ptt || vna, ptt && (pa_en || !tr_dis), ptt, ptt && pa_en, pa_en};
  endfunction

  // one command strobe with the shadow registers updated from the register map
  task automatic send_cmd(input radio_ctrl_pkg::cmd_addr_t addr,
                          input radio_ctrl_pkg::cmd_data_t data, input logic resp);
    @(posedge clock_2_5MHz);
    cmd_addr_i     <= addr;
    cmd_data_i     <= data;
    cmd_rqst_i     <= 1'b1;
    cmd_resprqst_i <= resp;
    if (addr == 6'h00)
      exp_chan = data[7:3];
    if (addr == 6'h09)
    begin
      exp_vna = data[23];
      exp_pa  = data[19];
      exp_tr  = data[18];
    end
    @(posedge clock_2_5MHz);
    cmd_rqst_i     <= 1'b0;
    cmd_resprqst_i <= 1'b0;
  endtask

  function automatic radio_ctrl_pkg::cmd_addr_t pick_addr();
    case ($urandom_range(0, 2))
      0:       return 6'h00;
      1:       return 6'h09;
      default: return radio_ctrl_pkg::cmd_addr_t'($urandom_range(0, 63));
    endcase
  endfunction

  // ------------------------------------------------------------
  // response port compare on the falling edge
  // ------------------------------------------------------------
  always @(negedge clock_2_5MHz)
  begin
    radio_ctrl_pkg::response_t word;
    logic                      full;
    if (!rst)
    begin
      full = (resp_model.size() >= RESP_DEPTH);
      check_bit("resp_valid_o", resp_model.size() != 0, resp_valid_o);
      // word taken by the host on the next edge
      if (resp_ready_i && resp_model.size() != 0)
      begin
        check_resp("resp_data_o", resp_model[0], resp_data_o);
        void'(resp_model.pop_front());
      end
      if (cmd_rqst_i && cmd_resprqst_i)
      begin
        word.addr = cmd_addr_i;
        word.data = cmd_data_i;
        // full queue loses the word
        if (full)
          dropped_resp++;
        else
          resp_model.push_back(word);
      end
    end
  end

  // ------------------------------------------------------------
  // cw envelope
  // ------------------------------------------------------------
  task automatic run_cw_envelope();
    radio_ctrl_pkg::cw_level_t exp_level;
    int                        wait_cycles;
    @(posedge clock_2_5MHz);
    cwkey_n_i <= 1'b0;
    wait_cycles = 0;
    @(negedge clock_2_5MHz);
    while (!cw_active_o && wait_cycles < DEBOUNCE + 4)
    begin
      @(negedge clock_2_5MHz);
      wait_cycles++;
    end
    if (!cw_active_o)
    begin
      other_errors++;
      $display("cw_active_o did not rise after the key went down");
    end
    // rise from 0 then hold at the ceiling
    exp_level = '0;
    repeat (LEVEL_MAX + 10)
    begin
      check_bit("cw_active_o", 1'b1, cw_active_o);
      check_level("cw_level_o", exp_level, cw_level_o);
      if (exp_level < LEVEL_MAX)
        exp_level++;
      @(negedge clock_2_5MHz);
    end
    @(posedge clock_2_5MHz);
    cwkey_n_i <= 1'b1;
    // ceiling held through the release debounce
    wait_cycles = 0;
    @(negedge clock_2_5MHz);
    while (cw_level_o == LEVEL_MAX && wait_cycles < DEBOUNCE + 4)
    begin
      check_bit("cw_active_o", 1'b1, cw_active_o);
      @(negedge clock_2_5MHz);
      wait_cycles++;
    end
    for (int i = LEVEL_MAX - 1; i >= 0; i--)
    begin
      check_bit("cw_active_o", 1'b1, cw_active_o);
      check_level("cw_level_o", radio_ctrl_pkg::cw_level_t'(i), cw_level_o);
      @(negedge clock_2_5MHz);
    end
    check_bit("cw_active_o", 1'b0, cw_active_o);
    // short pulse filtered out
    @(posedge clock_2_5MHz);
    cwkey_n_i <= 1'b0;
    repeat (DEBOUNCE - 2) @(posedge clock_2_5MHz);
    cwkey_n_i <= 1'b1;
    repeat (DEBOUNCE + 4)
    begin
      @(negedge clock_2_5MHz);
      check_bit("cw_active_o", 1'b0, cw_active_o);
      check_level("cw_level_o", '0, cw_level_o);
    end
  endtask

  // ------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------
  initial
  begin
    logic       queue_busy;
    logic       ready_next;
    int         hold;
    logic       host_ptt;
    logic       panel_ptt;
    logic       inhibit;
    logic [5:0] exp_tx;
    void'($urandom(32'h85ec4193));
    clock_2_5MHz   = 1'b0;
    rst            = 1'b1;
    cmd_addr_i     = '0;
    cmd_data_i     = '0;
    cmd_rqst_i     = 1'b0;
    cmd_resprqst_i = 1'b0;
    cmd_ptt_i      = 1'b0;
    cwkey_n_i      = 1'b1;
    ptt_n_i        = 1'b1;
    txinhibit_n_i  = 1'b1;
    resp_ready_i   = 1'b0;
    repeat (4) @(posedge clock_2_5MHz);
    rst <= 1'b0;

    // reset state
    @(negedge clock_2_5MHz);
    check_bit("ptt_o", 1'b0, ptt_o);
    check_bit("tx_en_o", 1'b0, tx_en_o);
    check_bit("vna_o", 1'b0, vna_o);
    check_bit("cw_active_o", 1'b0, cw_active_o);
    check_bit("pa_inttr_o", 1'b0, pa_inttr_o);
    check_bit("pa_exttr_o", 1'b0, pa_exttr_o);
    check_bit("pwr_envpa_o", 1'b0, pwr_envpa_o);
    check_bit("rfsw_sel_o", 1'b0, rfsw_sel_o);
    check_level("cw_level_o", '0, cw_level_o);
    check_chan("last_chan_o", '0, last_chan_o);

    // command decode
    resp_ready_i <= 1'b1;
    for (int i = 0; i < N_DECODE; i++)
    begin
      send_cmd(pick_addr(), $urandom, 1'b0);
      @(negedge clock_2_5MHz);
      check_chan("last_chan_o", exp_chan, last_chan_o);
      check_bit("vna_o", exp_vna, vna_o);
      check_bit("rfsw_sel_o", exp_pa, rfsw_sel_o);
    end

    // response queue with host stalls
    queue_busy = 1'b1;
    ready_next = 1'b1;
    fork
      begin
        for (int i = 0; i < N_QUEUE; i++)
        begin
          send_cmd(pick_addr(), $urandom, 1'($urandom_range(0, 1)));
          repeat ($urandom_range(0, 2)) @(posedge clock_2_5MHz);
        end
        queue_busy = 1'b0;
      end
      begin
        while (queue_busy)
        begin
          @(posedge clock_2_5MHz);
          ready_next = !ready_next;
          resp_ready_i <= ready_next;
          // long stalls fill the queue
          hold = ready_next ? $urandom_range(1, 3) : $urandom_range(6, 20);
          repeat (hold)
            if (queue_busy)
              @(posedge clock_2_5MHz);
        end
      end
    join
    @(posedge clock_2_5MHz);
    resp_ready_i <= 1'b1;
    while (resp_model.size() != 0)
      @(negedge clock_2_5MHz);
    @(negedge clock_2_5MHz);
    if (dropped_resp == 0)
    begin
      other_errors++;
      $display("response queue never filled, overflow drop was not exercised");
    end

    run_cw_envelope();

    // ptt and pa outputs
    for (int i = 0; i < N_TX; i++)
    begin
      send_cmd(6'h09, $urandom, 1'b0);
      host_ptt  = 1'($urandom_range(0, 1));
      panel_ptt = 1'($urandom_range(0, 1));
      inhibit   = 1'($urandom_range(0, 1));
      @(posedge clock_2_5MHz);
      cmd_ptt_i     <= host_ptt;
      ptt_n_i       <= ~panel_ptt;
      txinhibit_n_i <= ~inhibit;
      repeat (DEBOUNCE + 3) @(posedge clock_2_5MHz);
      @(negedge clock_2_5MHz);
      exp_tx = tx_reference(host_ptt, 1'b0, panel_ptt, inhibit, exp_vna, exp_pa, exp_tr);
      check_bit("cw_active_o", 1'b0, cw_active_o);
      check_bit("ptt_o", exp_tx[5], ptt_o);
      check_bit("tx_en_o", exp_tx[4], tx_en_o);
      check_bit("pa_inttr_o", exp_tx[3], pa_inttr_o);
      check_bit("pa_exttr_o", exp_tx[2], pa_exttr_o);
      check_bit("pwr_envpa_o", exp_tx[1], pwr_envpa_o);
      check_bit("rfsw_sel_o", exp_tx[0], rfsw_sel_o);
    end

    repeat (2) @(posedge clock_2_5MHz);
    $display("summary: %0d mismatches, %0d other errors, %0d assertion failures",
             mismatch_count, other_errors,
             radio_ctrl_top_inst.radio_ctrl_checker_inst.assert_failures);
    if (mismatch_count == 0 && other_errors == 0 &&
        radio_ctrl_top_inst.radio_ctrl_checker_inst.assert_failures == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

  // run length bound
  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge clock_2_5MHz);
    $display("timeout: run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

//--- src.f
radio_ctrl_pkg.sv
input_debounce.sv
cw_keyer.sv
cmd_decoder.sv
response_fifo.sv
tx_switching.sv
radio_ctrl_top.sv
radio_ctrl_checker.sv
tb_radio_ctrl.sv

//--- Bender.yml
package:
  name: radio_ctrl

sources:
  - radio_ctrl_pkg.sv
  - input_debounce.sv
  - cw_keyer.sv
  - cmd_decoder.sv
  - response_fifo.sv
  - tx_switching.sv
  - radio_ctrl_top.sv
  - target: simulation
    files:
      - radio_ctrl_checker.sv
      - tb_radio_ctrl.sv
